//--- common/cpu_pkg.sv
package cpu_pkg;

    localparam int data_w    = 8;    // data and address width
    localparam int reg_idx_w = 2;    // four registers
    localparam int mem_depth = 256;  // shared code and data bytes

    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_mov = 4'h1,  // ra <- rb
        op_add = 4'h2,
        op_sub = 4'h3,
        op_and = 4'h4,
        op_or  = 4'h5,
        op_inc = 4'h6,  // ra <- ra + 1
        op_not = 4'h7,  // ra <- ~ra
        op_in  = 4'h8,  // ra <- input port
        op_out = 4'h9,  // output port <- rb
        op_ldm = 4'ha,  // two bytes, ra <- imm
        op_ldd = 4'hb,  // ra <- mem[rb]
        op_std = 4'hc,  // mem[rb] <- ra
        op_jz  = 4'hd,
        op_jc  = 4'he,
        op_jmp = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        wb_alu,     // alu result
        wb_mem,     // load data
        wb_in_port  // sampled input port
    } wb_src_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,  // ex/mem result
        fwd_from_wb    // writeback value
    } fwd_sel_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        opcode_t op;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    port_write;
        wb_src_t wb_src;
        logic    is_branch;
        logic    is_two_byte;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [data_w-1:0]    pc_plus1;
        logic [data_w-1:0]    ra_val;
        logic [data_w-1:0]    rb_val;
        logic [reg_idx_w-1:0] ra;
        logic [reg_idx_w-1:0] rb;
        logic [data_w-1:0]    imm;       // port sample for IN
    } id_ex_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [data_w-1:0]    alu_res;
        logic [data_w-1:0]    store_val;
        logic [data_w-1:0]    addr;      // forwarded rb
        logic [reg_idx_w-1:0] rd;
        logic [data_w-1:0]    in_val;
    } ex_mem_t;

    typedef struct packed {
        logic                 reg_write;
        logic                 port_write;
        wb_src_t              wb_src;
        logic [data_w-1:0]    alu_res;
        logic [data_w-1:0]    mem_data;
        logic [data_w-1:0]    in_val;
        logic [reg_idx_w-1:0] rd;
        logic [data_w-1:0]    out_val;
    } mem_wb_t;

endpackage

//--- decode/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  cpu_pkg::opcode_t op,
    output cpu_pkg::ctrl_t   ctrl
);

    always_comb begin
        ctrl        = '0;  // nop unless decoded below
        ctrl.op     = op;
        ctrl.wb_src = cpu_pkg::wb_alu;
        case (op)
            cpu_pkg::op_mov,
            cpu_pkg::op_add,
            cpu_pkg::op_sub,
            cpu_pkg::op_and,
            cpu_pkg::op_or,
            cpu_pkg::op_inc,
            cpu_pkg::op_not: begin
                ctrl.reg_write = 1'b1;  // alu result to ra
            end
            cpu_pkg::op_in: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = cpu_pkg::wb_in_port;
            end
            cpu_pkg::op_out: begin
                ctrl.port_write = 1'b1;
            end
            cpu_pkg::op_ldm: begin
                ctrl.reg_write   = 1'b1;  // imm passes through alu
                ctrl.is_two_byte = 1'b1;
            end
            cpu_pkg::op_ldd: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_src    = cpu_pkg::wb_mem;
            end
            cpu_pkg::op_std: begin
                ctrl.mem_write = 1'b1;
            end
            cpu_pkg::op_jz,
            cpu_pkg::op_jc,
            cpu_pkg::op_jmp: begin
                ctrl.is_branch = 1'b1;  // condition checked in execute
            end
            default: begin
            end
        endcase
    end

endmodule

//--- decode/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [cpu_pkg::reg_idx_w-1:0] ra,
    input  logic [cpu_pkg::reg_idx_w-1:0] rb,
    input  logic [cpu_pkg::reg_idx_w-1:0] rd,
    input  logic                          we,
    input  logic [cpu_pkg::data_w-1:0]    wdata,
    output logic [cpu_pkg::data_w-1:0]    ra_val,
    output logic [cpu_pkg::data_w-1:0]    rb_val
);

    logic [cpu_pkg::data_w-1:0] regs [2**cpu_pkg::reg_idx_w];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // write-through, decode sees the value retiring this cycle
    assign ra_val = (we && rd == ra) ? wdata : regs[ra];
    assign rb_val = (we && rd == rb) ? wdata : regs[rb];

endmodule

//--- execute/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_t           op,
    input  logic [cpu_pkg::data_w-1:0] a,
    input  logic [cpu_pkg::data_w-1:0] b,
    output logic [cpu_pkg::data_w-1:0] res,
    output cpu_pkg::flags_t            flags,
    output cpu_pkg::flags_t            flag_mask
);

    logic [cpu_pkg::data_w:0] wide;  // msb is carry or borrow
    logic                     ovf;

    always_comb begin
        wide      = {1'b0, b};  // mov, ldm, out pass b
        ovf       = 1'b0;
        flag_mask = '0;
        case (op)
            cpu_pkg::op_add: begin
                wide      = {1'b0, a} + {1'b0, b};
                ovf       = (a[cpu_pkg::data_w-1] == b[cpu_pkg::data_w-1]) &&
                            (wide[cpu_pkg::data_w-1] != a[cpu_pkg::data_w-1]);
                flag_mask = '1;
            end
            cpu_pkg::op_sub: begin
                wide      = {1'b0, a} - {1'b0, b};  // msb set on borrow
                ovf       = (a[cpu_pkg::data_w-1] != b[cpu_pkg::data_w-1]) &&
                            (wide[cpu_pkg::data_w-1] != a[cpu_pkg::data_w-1]);
                flag_mask = '1;
            end
            cpu_pkg::op_inc: begin
                wide      = {1'b0, a} + 1'b1;
                ovf       = (a == {1'b0, {(cpu_pkg::data_w-1){1'b1}}});  // 7f -> 80
                flag_mask = '1;
            end
            cpu_pkg::op_and: begin
                wide        = {1'b0, a & b};
                flag_mask.z = 1'b1;
                flag_mask.n = 1'b1;
            end
            cpu_pkg::op_or: begin
                wide        = {1'b0, a | b};
                flag_mask.z = 1'b1;
                flag_mask.n = 1'b1;
            end
            cpu_pkg::op_not: begin
                wide        = {1'b0, ~a};
                flag_mask.z = 1'b1;
                flag_mask.n = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign res     = wide[cpu_pkg::data_w-1:0];
    assign flags.z = (res == '0);
    assign flags.n = res[cpu_pkg::data_w-1];
    assign flags.c = wide[cpu_pkg::data_w];
    assign flags.v = ovf;

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cpu_pkg::id_ex_t            id_ex_in,
    input  logic                       bubble,
    input  cpu_pkg::fwd_sel_t          fwd_a,
    input  cpu_pkg::fwd_sel_t          fwd_b,
    input  logic [cpu_pkg::data_w-1:0] mem_val,
    input  logic [cpu_pkg::data_w-1:0] wb_val,
    output cpu_pkg::id_ex_t            id_ex_q,
    output logic [cpu_pkg::data_w-1:0] alu_res,
    output logic [cpu_pkg::data_w-1:0] store_val,
    output logic                       branch_taken,
    output logic [cpu_pkg::data_w-1:0] branch_target
);

    logic [cpu_pkg::data_w-1:0] op_a;
    logic [cpu_pkg::data_w-1:0] op_b;
    logic [cpu_pkg::data_w-1:0] alu_b;
    cpu_pkg::flags_t            flags_q;
    cpu_pkg::flags_t            alu_flags;
    cpu_pkg::flags_t            flag_mask;

    function automatic logic [cpu_pkg::data_w-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_t          sel,
        input logic [cpu_pkg::data_w-1:0] reg_val,
        input logic [cpu_pkg::data_w-1:0] m_val,
        input logic [cpu_pkg::data_w-1:0] w_val
    );
        case (sel)
            cpu_pkg::fwd_from_mem: return m_val;
            cpu_pkg::fwd_from_wb:  return w_val;
            default:               return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_q <= '0;
        end else if (bubble) begin
            id_ex_q <= '0;  // zero ctrl is a nop
        end else begin
            id_ex_q <= id_ex_in;
        end
    end

    assign op_a  = fwd_mux(fwd_a, id_ex_q.ra_val, mem_val, wb_val);
    assign op_b  = fwd_mux(fwd_b, id_ex_q.rb_val, mem_val, wb_val);
    assign alu_b = (id_ex_q.ctrl.op == cpu_pkg::op_ldm) ? id_ex_q.imm : op_b;

    alu alu_i (
        .op        (id_ex_q.ctrl.op),
        .a         (op_a),
        .b         (alu_b),
        .res       (alu_res),
        .flags     (alu_flags),
        .flag_mask (flag_mask)
    );

    // only masked flags change, the rest keep their value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_q <= '0;
        end else begin
            flags_q <= cpu_pkg::flags_t'((flags_q & ~flag_mask) | (alu_flags & flag_mask));
        end
    end

    assign branch_taken = id_ex_q.ctrl.is_branch &&
                          ((id_ex_q.ctrl.op == cpu_pkg::op_jmp) ||
                           (id_ex_q.ctrl.op == cpu_pkg::op_jz && flags_q.z) ||
                           (id_ex_q.ctrl.op == cpu_pkg::op_jc && flags_q.c));
    assign branch_target = op_b;  // jump address in rb
    assign store_val     = op_a;  // std writes ra

endmodule

//--- execute/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [cpu_pkg::reg_idx_w-1:0] id_ra,
    input  logic [cpu_pkg::reg_idx_w-1:0] id_rb,
    input  cpu_pkg::id_ex_t               ex,
    input  logic [cpu_pkg::reg_idx_w-1:0] mem_rd,
    input  logic                          mem_reg_write,
    input  logic [cpu_pkg::reg_idx_w-1:0] wb_rd,
    input  logic                          wb_reg_write,
    input  logic                          branch_taken,
    output cpu_pkg::fwd_sel_t             fwd_a,
    output cpu_pkg::fwd_sel_t             fwd_b,
    output logic                          stall,
    output logic                          flush
);

    // newest producer wins, so EX/MEM is checked first
    function automatic cpu_pkg::fwd_sel_t fwd_pick(
        input logic [cpu_pkg::reg_idx_w-1:0] src
    );
        if (mem_reg_write && mem_rd == src) begin
            return cpu_pkg::fwd_from_mem;
        end
        if (wb_reg_write && wb_rd == src) begin
            return cpu_pkg::fwd_from_wb;
        end
        return cpu_pkg::fwd_none;
    endfunction

    always_comb begin
        fwd_a = fwd_pick(ex.ra);
        fwd_b = fwd_pick(ex.rb);
    end

    // load data only exists after MEM, hold decode one cycle
    assign stall = ex.ctrl.mem_read && (ex.ra == id_ra || ex.ra == id_rb);

    assign flush = branch_taken;  // kills the two younger slots

endmodule

//--- sim.f
common/cpu_pkg.sv
verilog/unified_memory.sv
decode/control_unit.sv
decode/register_file.sv
execute/alu.sv
execute/hazard_unit.sv
execute/execute_stage.sv
verilog/cpu_top.sv
test/tb_clock_gen.sv
test/cpu_sva.sv
test/cpu_tb.sv

//--- test/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       out_strobe,
    input logic [cpu_pkg::data_w-1:0] out_port,
    input logic                       stall,
    input logic                       flush
);

    int fail_count = 0;  // failures seen so far

    // nothing retires while the core is held
    strobe_in_reset: assert property (@(posedge clk) !arst_n |-> !out_strobe)
        else begin
            fail_count++;
            $error("out_strobe high while arst_n is low");
        end

    // stall needs a load in EX, flush needs a branch there
    stall_flush_excl: assert property (@(posedge clk) disable iff (!arst_n) !(stall && flush))
        else begin
            fail_count++;
            $error("stall and flush high in the same cycle");
        end

    port_idle_zero: assert property (@(posedge clk) disable iff (!arst_n)
                                     !out_strobe |-> out_port == '0)
        else begin
            fail_count++;
            $error("out_port not zero while out_strobe is low");
        end

endmodule

bind cpu_top cpu_sva cpu_sva_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_strobe (out_strobe),
    .out_port   (out_port),
    .stall      (stall),
    .flush      (flush)
);

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    logic                       clk;
    logic                       arst_n;
    logic                       rst_req;
    logic [cpu_pkg::data_w-1:0] in_port;
    logic [cpu_pkg::data_w-1:0] out_port;
    logic                       out_strobe;
    logic [cpu_pkg::data_w-1:0] image [cpu_pkg::mem_depth];  // program and data image
    logic [cpu_pkg::data_w-1:0] exp_q [$];
    logic [cpu_pkg::data_w-1:0] got_q [$];
    logic [31:0]                lfsr_q;
    int                         wr_ptr;  // next free program byte
    int                         checks;
    int                         errors;
    int                         timeouts;

    tb_clock_gen clk_gen_i (
        .rst_req (rst_req),
        .clk     (clk),
        .arst_n  (arst_n)
    );

    cpu_top cpu_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_port    (in_port),
        .out_port   (out_port),
        .out_strobe (out_strobe)
    );

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [cpu_pkg::data_w-1:0] rand_byte();
        logic [cpu_pkg::data_w-1:0] val;
        val = '0;
        for (int i = 0; i < cpu_pkg::data_w; i++) begin
            val    = {val[cpu_pkg::data_w-2:0], lfsr_q[31]};  // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
        return val;
    endfunction

    function automatic logic [cpu_pkg::data_w-1:0] encode(cpu_pkg::opcode_t op, int ra, int rb);
        return {op, 2'(ra), 2'(rb)};
    endfunction

    task automatic clear_image();
        for (int a = 0; a < cpu_pkg::mem_depth; a++) begin
            image[a] = 8'(a * 37 + 8'h5b);  // odd stride, every address bit counts
        end
        wr_ptr = 0;
        exp_q.delete();
    endtask

    task automatic emit(cpu_pkg::opcode_t op, int ra, int rb);
        image[wr_ptr] = encode(op, ra, rb);
        wr_ptr++;
    endtask

    task automatic emit_ldm(int ra, logic [cpu_pkg::data_w-1:0] imm);
        emit(cpu_pkg::op_ldm, ra, 0);
        image[wr_ptr] = imm;
        wr_ptr++;
    endtask

    // r3 points at the jmp itself, core spins there
    task automatic emit_halt();
        emit_ldm(3, 8'(wr_ptr + 2));
        emit(cpu_pkg::op_jmp, 0, 3);
    endtask

    task automatic check_data(input string what, input logic [cpu_pkg::data_w-1:0] got,
                              input logic [cpu_pkg::data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %0h, expected %0h", what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %s: got %0h, expected %0h", what, got, exp);
        end
    endtask

    task automatic check_strobe(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %0h, expected %0h", what, got, exp);
        end
    endtask

    // memory is written while the core is held in reset
    task automatic start_program(input logic [cpu_pkg::data_w-1:0] in_val);
        int waited;
        @(posedge clk);
        rst_req <= 1'b1;
        in_port <= in_val;  // held for the whole run
        @(posedge clk);
        rst_req <= 1'b0;
        waited = 0;
        while (arst_n !== 1'b0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b0) begin
            timeouts++;
            $display("reset was never asserted after the request");
        end
        for (int a = 0; a < cpu_pkg::mem_depth; a++) begin
            cpu_top_i.mem_i.mem[a] = image[a];
        end
        waited = 0;
        while (arst_n !== 1'b1 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end
    endtask

    task automatic collect_and_compare(input string test);
        int waited;
        got_q.delete();
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < 400) begin
            @(negedge clk);  // outputs settled since the rising edge
            waited++;
            if (out_strobe) got_q.push_back(out_port);
        end
        if (got_q.size() < exp_q.size()) begin
            timeouts++;
            $display("timeout in %s: %0d of %0d strobes seen", test, got_q.size(), exp_q.size());
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);  // stray strobes from flushed slots land here
            if (out_strobe) got_q.push_back(out_port);
        end
        check_count($sformatf("out_strobe count in %s", test), got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_data($sformatf("out_port[%0d] in %s", i, test), got_q[i], exp_q[i]);
        end
    endtask

    task automatic test_arith();
        logic [cpu_pkg::data_w-1:0] a;
        logic [cpu_pkg::data_w-1:0] b;
        a = rand_byte();
        b = rand_byte();
        clear_image();
        emit_ldm(0, a);
        emit_ldm(1, b);
        emit(cpu_pkg::op_mov, 2, 0);  // r0 from writeback
        emit(cpu_pkg::op_add, 2, 1);  // r2 from ex/mem
        emit(cpu_pkg::op_out, 0, 2);
        emit(cpu_pkg::op_mov, 3, 0);
        emit(cpu_pkg::op_sub, 3, 1);
        emit(cpu_pkg::op_out, 0, 3);
        emit(cpu_pkg::op_mov, 2, 0);
        emit(cpu_pkg::op_and, 2, 1);
        emit(cpu_pkg::op_out, 0, 2);
        emit(cpu_pkg::op_mov, 3, 0);
        emit(cpu_pkg::op_or, 3, 1);
        emit(cpu_pkg::op_out, 0, 3);
        emit(cpu_pkg::op_inc, 0, 0);
        emit(cpu_pkg::op_out, 0, 0);
        emit(cpu_pkg::op_not, 1, 0);
        emit(cpu_pkg::op_out, 0, 1);
        emit_halt();
        exp_q = '{8'(a + b), 8'(a - b), a & b, a | b, 8'(a + 1), ~b};
        start_program(8'h00);
        collect_and_compare("arith");
    endtask

    task automatic test_memory();
        logic [cpu_pkg::data_w-1:0] a1;
        logic [cpu_pkg::data_w-1:0] a2;
        logic [cpu_pkg::data_w-1:0] v1;
        logic [cpu_pkg::data_w-1:0] v2;
        a1 = 8'hc0 | (rand_byte() & 8'h1f);  // two disjoint windows above the code
        a2 = 8'he0 | (rand_byte() & 8'h1f);
        v1 = rand_byte();
        v2 = rand_byte();
        clear_image();
        emit_ldm(0, a1);
        emit_ldm(1, v1);
        emit(cpu_pkg::op_std, 1, 0);
        emit_ldm(2, a2);
        emit_ldm(3, v2);
        emit(cpu_pkg::op_std, 3, 2);
        emit_ldm(1, 8'h00);  // wipe before reading back
        emit_ldm(3, 8'h00);
        emit(cpu_pkg::op_ldd, 1, 0);
        emit(cpu_pkg::op_ldd, 3, 2);
        emit(cpu_pkg::op_out, 0, 1);
        emit(cpu_pkg::op_out, 0, 3);
        emit_halt();
        exp_q = '{v1, v2};
        start_program(8'h00);
        collect_and_compare("memory");
    endtask

    task automatic test_load_use();
        logic [cpu_pkg::data_w-1:0] addr;
        logic [cpu_pkg::data_w-1:0] x1;
        logic [cpu_pkg::data_w-1:0] x2;
        logic [cpu_pkg::data_w-1:0] y;
        addr = 8'hd0 | (rand_byte() & 8'h07);
        x1   = rand_byte();
        x2   = rand_byte();
        y    = rand_byte();
        clear_image();
        image[addr]     = x1;
        image[addr + 1] = x2;
        emit_ldm(0, addr);
        emit_ldm(2, y);
        emit(cpu_pkg::op_ldd, 1, 0);
        emit(cpu_pkg::op_add, 1, 2);  // loaded reg as ra
        emit(cpu_pkg::op_out, 0, 1);
        emit(cpu_pkg::op_inc, 0, 0);
        emit(cpu_pkg::op_ldd, 3, 0);
        emit(cpu_pkg::op_add, 2, 3);  // loaded reg as rb
        emit(cpu_pkg::op_out, 0, 2);
        emit_halt();
        exp_q = '{8'(x1 + y), 8'(y + x2)};
        start_program(8'h00);
        collect_and_compare("load_use");
    endtask

    task automatic test_branch();
        logic [cpu_pkg::data_w-1:0] v;
        logic [cpu_pkg::data_w-1:0] w;
        logic [cpu_pkg::data_w-1:0] m;
        int                         fix;
        v = rand_byte();
        w = v ^ (rand_byte() | 8'h01);  // never equal to v
        m = rand_byte();
        clear_image();
        emit_ldm(3, m);  // marker
        emit_ldm(0, v);
        emit_ldm(1, v);
        fix = wr_ptr + 1;
        emit_ldm(2, 8'h00);
        emit(cpu_pkg::op_sub, 1, 0);  // sets Z
        emit(cpu_pkg::op_nop, 0, 0);
        emit(cpu_pkg::op_jz, 0, 2);
        emit(cpu_pkg::op_out, 0, 3);  // both flushed
        emit(cpu_pkg::op_out, 0, 3);
        image[fix] = 8'(wr_ptr);
        emit(cpu_pkg::op_out, 0, 0);
        emit_ldm(1, w);
        fix = wr_ptr + 1;
        emit_ldm(2, 8'h00);
        emit(cpu_pkg::op_sub, 1, 0);  // clears Z
        emit(cpu_pkg::op_nop, 0, 0);
        emit(cpu_pkg::op_jz, 0, 2);
        emit(cpu_pkg::op_out, 0, 3);  // falls through
        image[fix] = 8'(wr_ptr);
        emit(cpu_pkg::op_out, 0, 0);
        fix = wr_ptr + 1;
        emit_ldm(2, 8'h00);
        emit(cpu_pkg::op_jmp, 0, 2);
        emit(cpu_pkg::op_out, 0, 3);
        emit(cpu_pkg::op_out, 0, 3);
        image[fix] = 8'(wr_ptr);
        emit(cpu_pkg::op_out, 0, 1);
        emit_halt();
        exp_q = '{v, m, v, 8'(w - v)};
        start_program(8'h00);
        collect_and_compare("branch");
    endtask

    task automatic run_carry(input logic [cpu_pkg::data_w-1:0] a,
                             input logic [cpu_pkg::data_w-1:0] b, input string test);
        logic [cpu_pkg::data_w:0]   sum;
        logic [cpu_pkg::data_w-1:0] in_val;
        int                         fix;
        sum    = {1'b0, a} + {1'b0, b};
        in_val = rand_byte();
        clear_image();
        emit_ldm(0, a);
        emit_ldm(1, b);
        fix = wr_ptr + 1;
        emit_ldm(2, 8'h00);
        emit(cpu_pkg::op_add, 0, 1);
        emit(cpu_pkg::op_nop, 0, 0);
        emit(cpu_pkg::op_jc, 0, 2);
        emit(cpu_pkg::op_out, 0, 1);  // only on no carry
        emit(cpu_pkg::op_out, 0, 1);
        image[fix] = 8'(wr_ptr);
        emit(cpu_pkg::op_out, 0, 0);
        emit(cpu_pkg::op_in, 2, 0);
        emit(cpu_pkg::op_out, 0, 2);
        emit_halt();
        if (sum <= 9'd255) begin
            exp_q.push_back(b);
            exp_q.push_back(b);
        end
        exp_q.push_back(sum[cpu_pkg::data_w-1:0]);
        exp_q.push_back(in_val);
        start_program(in_val);
        collect_and_compare(test);
    endtask

    task automatic test_carry_and_input();
        logic [cpu_pkg::data_w-1:0] a;
        a = rand_byte();
        run_carry(a, rand_byte(), "carry_random");
        run_carry(a, ~a, "carry_none");  // sum is ff
        run_carry(rand_byte() | 8'h80, rand_byte() | 8'h80, "carry_forced");
    endtask

    task automatic test_reset();
        clear_image();
        emit(cpu_pkg::op_out, 0, 0);  // OUT at address 0
        emit_halt();
        exp_q = '{8'h00};  // r0 clears on reset
        start_program(rand_byte());
        for (int i = 1; i <= 4; i++) begin
            @(negedge clk);
            check_strobe($sformatf("out_strobe at edge %0d after reset", i), out_strobe, 1'b0);
        end
        collect_and_compare("reset");
    endtask

    initial begin
        lfsr_q   = 32'he1a9;
        rst_req  = 1'b0;
        in_port  = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        test_arith();
        test_memory();
        test_load_use();
        test_branch();
        test_carry_and_input();
        test_reset();
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, cpu_top_i.cpu_sva_i.fail_count);
        if (errors == 0 && timeouts == 0 && cpu_top_i.cpu_sva_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    input  logic rst_req,
    output logic clk,
    output logic arst_n
);

    int rst_left;  // falling edges until release

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b1;
        rst_left = 0;
        #1;
        arst_n   = 1'b0;  // real edge, so every async flop clears
        rst_left = 3;
    end

    always #5 clk = ~clk;  // 10 ns period

    // reset moves on falling edges, away from the DUT's active edge
    always @(negedge clk) begin
        if (rst_req) begin
            arst_n   <= 1'b0;
            rst_left <= 3;  // three rising edges held
        end else if (rst_left == 1) begin
            arst_n   <= 1'b1;
            rst_left <= 0;
        end else if (rst_left > 1) begin
            rst_left <= rst_left - 1;
        end
    end

endmodule

//--- verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::data_w-1:0] in_port,
    output logic [cpu_pkg::data_w-1:0] out_port,
    output logic                       out_strobe
);

    typedef struct packed {
        logic [cpu_pkg::data_w-1:0] instr;
        logic [cpu_pkg::data_w-1:0] imm;
        logic [cpu_pkg::data_w-1:0] in_val;
        logic [cpu_pkg::data_w-1:0] pc_plus1;
    } if_id_t;

    logic [cpu_pkg::data_w-1:0] pc;
    logic [cpu_pkg::data_w-1:0] pc_step;
    logic [cpu_pkg::data_w-1:0] pc_seq;
    logic [cpu_pkg::data_w-1:0] fetch_instr;
    logic [cpu_pkg::data_w-1:0] fetch_imm;
    logic [cpu_pkg::data_w-1:0] ra_val;
    logic [cpu_pkg::data_w-1:0] rb_val;
    logic [cpu_pkg::data_w-1:0] alu_res;
    logic [cpu_pkg::data_w-1:0] store_val;
    logic [cpu_pkg::data_w-1:0] branch_target;
    logic [cpu_pkg::data_w-1:0] mem_rdata;
    logic [cpu_pkg::data_w-1:0] mem_val;
    logic [cpu_pkg::data_w-1:0] wb_val;
    logic                       branch_taken;
    logic                       stall;
    logic                       flush;
    cpu_pkg::fwd_sel_t          fwd_a;
    cpu_pkg::fwd_sel_t          fwd_b;
    cpu_pkg::ctrl_t             fetch_ctrl;
    cpu_pkg::ctrl_t             dec_ctrl;
    if_id_t                     if_id_q;
    cpu_pkg::id_ex_t            id_ex_in;
    cpu_pkg::id_ex_t            id_ex_q;
    cpu_pkg::ex_mem_t           ex_mem_q;
    cpu_pkg::mem_wb_t           mem_wb_q;

    unified_memory mem_i (
        .clk        (clk),
        .instr_addr (pc),
        .instr      (fetch_instr),
        .imm        (fetch_imm),
        .data_addr  (ex_mem_q.addr),
        .data_we    (ex_mem_q.ctrl.mem_write),
        .data_wdata (ex_mem_q.store_val),
        .data_rdata (mem_rdata)
    );

    // predecode in fetch, only the length bit is needed here
    control_unit fetch_dec_i (
        .op   (cpu_pkg::opcode_t'(fetch_instr[7:4])),
        .ctrl (fetch_ctrl)
    );

    assign pc_step = fetch_ctrl.is_two_byte ? 2 : 1;  // ldm skips its immediate
    assign pc_seq  = pc + pc_step;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branch_target;  // redirect from execute
        end else if (!stall) begin
            pc <= pc_seq;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_q <= '0;
        end else if (flush) begin
            if_id_q <= '0;  // squash wrong-path slot
        end else if (!stall) begin
            if_id_q.instr    <= fetch_instr;
            if_id_q.imm      <= fetch_imm;
            if_id_q.in_val   <= in_port;  // port sampled on entry to decode
            if_id_q.pc_plus1 <= pc_seq;
        end
    end

    control_unit dec_i (
        .op   (cpu_pkg::opcode_t'(if_id_q.instr[7:4])),
        .ctrl (dec_ctrl)
    );

    register_file rf_i (
        .clk    (clk),
        .arst_n (arst_n),
        .ra     (if_id_q.instr[3:2]),
        .rb     (if_id_q.instr[1:0]),
        .rd     (mem_wb_q.rd),
        .we     (mem_wb_q.reg_write),
        .wdata  (wb_val),
        .ra_val (ra_val),
        .rb_val (rb_val)
    );

    always_comb begin
        id_ex_in.ctrl     = dec_ctrl;
        id_ex_in.pc_plus1 = if_id_q.pc_plus1;
        id_ex_in.ra_val   = ra_val;
        id_ex_in.rb_val   = rb_val;
        id_ex_in.ra       = if_id_q.instr[3:2];
        id_ex_in.rb       = if_id_q.instr[1:0];
        // IN carries its port sample in the imm slot
        id_ex_in.imm = (dec_ctrl.wb_src == cpu_pkg::wb_in_port) ? if_id_q.in_val
                                                                : if_id_q.imm;
    end

    hazard_unit hz_i (
        .id_ra         (if_id_q.instr[3:2]),
        .id_rb         (if_id_q.instr[1:0]),
        .ex            (id_ex_q),
        .mem_rd        (ex_mem_q.rd),
        .mem_reg_write (ex_mem_q.ctrl.reg_write),
        .wb_rd         (mem_wb_q.rd),
        .wb_reg_write  (mem_wb_q.reg_write),
        .branch_taken  (branch_taken),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall),
        .flush         (flush)
    );

    execute_stage ex_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .id_ex_in      (id_ex_in),
        .bubble        (stall | flush),  // nop into ID/EX
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_val       (mem_val),
        .wb_val        (wb_val),
        .id_ex_q       (id_ex_q),
        .alu_res       (alu_res),
        .store_val     (store_val),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.ctrl      <= id_ex_q.ctrl;
            ex_mem_q.alu_res   <= alu_res;
            ex_mem_q.store_val <= store_val;
            ex_mem_q.addr      <= branch_target;  // rb is address and port value too
            ex_mem_q.rd        <= id_ex_q.ra;
            ex_mem_q.in_val    <= id_ex_q.imm;
        end
    end

    // load data not ready here, load-use stall covers it
    assign mem_val = (ex_mem_q.ctrl.wb_src == cpu_pkg::wb_in_port) ? ex_mem_q.in_val
                                                                   : ex_mem_q.alu_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.reg_write  <= ex_mem_q.ctrl.reg_write;
            mem_wb_q.port_write <= ex_mem_q.ctrl.port_write;
            mem_wb_q.wb_src     <= ex_mem_q.ctrl.wb_src;
            mem_wb_q.alu_res    <= ex_mem_q.alu_res;
            mem_wb_q.mem_data   <= mem_rdata;
            mem_wb_q.in_val     <= ex_mem_q.in_val;
            mem_wb_q.rd         <= ex_mem_q.rd;
            mem_wb_q.out_val    <= ex_mem_q.ctrl.port_write ? ex_mem_q.addr : '0;
        end
    end

    always_comb begin
        case (mem_wb_q.wb_src)
            cpu_pkg::wb_mem:     wb_val = mem_wb_q.mem_data;
            cpu_pkg::wb_in_port: wb_val = mem_wb_q.in_val;
            default:             wb_val = mem_wb_q.alu_res;
        endcase
    end

    // output port updates on the writeback edge, same as the regfile
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_port   <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_port   <= mem_wb_q.out_val;  // already zero unless OUT
            out_strobe <= mem_wb_q.port_write;
        end
    end

endmodule

//--- verilog/unified_memory.sv
`timescale 1ns/1ps

module unified_memory (
    input  logic                       clk,
    input  logic [cpu_pkg::data_w-1:0] instr_addr,
    output logic [cpu_pkg::data_w-1:0] instr,
    output logic [cpu_pkg::data_w-1:0] imm,
    input  logic [cpu_pkg::data_w-1:0] data_addr,
    input  logic                       data_we,
    input  logic [cpu_pkg::data_w-1:0] data_wdata,
    output logic [cpu_pkg::data_w-1:0] data_rdata
);

    logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::mem_depth];  // code and data share this
    logic [cpu_pkg::data_w-1:0] imm_addr;

    assign imm_addr = instr_addr + 1'b1;  // wraps at 255

    assign instr      = mem[instr_addr];  // async fetch tap
    assign imm        = mem[imm_addr];    // second byte of ldm
    assign data_rdata = mem[data_addr];

    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[data_addr] <= data_wdata;  // std
        end
    end

endmodule
